// File: compile.f
+incdir+include
verilog/ptab_pkg.sv
verilog/ptab_table.sv
verilog/ptab_match.sv
verilog/ptab.sv
verilog/predecode_check.sv
verilog/exe_check.sv
verilog/ptab_frontend.sv
verification/ptab_frontend_tb.sv

// File: include/ptab_consts.svh
`ifndef PTAB_CONSTS_SVH
`define PTAB_CONSTS_SVH

//////////////////////////////
// table geometry
//////////////////////////////

// entries held in the predicted-target buffer
`define PTAB_ENTRIES 16

// bits needed to index one entry
`define PTAB_IDX_W 4

//////////////////////////////
// address width
//////////////////////////////

// word pc, byte offset dropped
`define PC_W 30

`endif

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module ptab_frontend_tb -o ptab_sim

out=$(./obj_dir/ptab_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
    exit 0
else
    exit 1
fi

// File: verification/ptab_frontend_tb.sv
`include "ptab_consts.svh"

module ptab_frontend_tb;

    import ptab_pkg::*;

    // longest test run in cycles, rounded up
    localparam int STIM_CYCLES = 300;
    localparam int MAX_CYCLES  = 2 * STIM_CYCLES;

    logic      clk;
    logic      rstn;
    pd_req_t   pd_req;
    exe_req_t  exe_req;
    redirect_t pd_redirect;
    redirect_t exe_redirect;

    // expected redirects, registered like the DUT outputs
    redirect_t exp_pd;
    redirect_t exp_exe;
    redirect_t exp_pd_d;
    redirect_t exp_exe_d;

    // reference table
    logic [`PTAB_ENTRIES-1:0] m_valid;
    word_pc_t                 m_pc [`PTAB_ENTRIES];
    word_pc_t                 m_target [`PTAB_ENTRIES];

    int     errors            = 0;
    int     tests             = 0;
    int     failed_tests      = 0;
    int     test_start_errors = 0;
    int     cycles            = 0;
    integer seed              = 42778;

    ptab_frontend dut (
        .clk          (clk),
        .rstn         (rstn),
        .pd_req       (pd_req),
        .exe_req      (exe_req),
        .pd_redirect  (pd_redirect),
        .exe_redirect (exe_redirect)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        if (!rstn)
        begin
            exp_pd  <= '0;
            exp_exe <= '0;
        end
        else
        begin
            exp_pd  <= exp_pd_d;
            exp_exe <= exp_exe_d;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    a_pd_valid: assert property (@(posedge clk) disable iff (!rstn)
        pd_redirect.valid == exp_pd.valid)
    else
    begin
        $display("MISMATCH pd_redirect.valid: got %h expected %h",
                 $sampled(pd_redirect.valid), $sampled(exp_pd.valid));
        errors = errors + 1;
    end

    a_pd_target: assert property (@(posedge clk) disable iff (!rstn)
        exp_pd.valid |-> pd_redirect.target == exp_pd.target)
    else
    begin
        $display("MISMATCH pd_redirect.target: got %h expected %h",
                 $sampled(pd_redirect.target), $sampled(exp_pd.target));
        errors = errors + 1;
    end

    a_exe_valid: assert property (@(posedge clk) disable iff (!rstn)
        exe_redirect.valid == exp_exe.valid)
    else
    begin
        $display("MISMATCH exe_redirect.valid: got %h expected %h",
                 $sampled(exe_redirect.valid), $sampled(exp_exe.valid));
        errors = errors + 1;
    end

    a_exe_target: assert property (@(posedge clk) disable iff (!rstn)
        exp_exe.valid |-> exe_redirect.target == exp_exe.target)
    else
    begin
        $display("MISMATCH exe_redirect.target: got %h expected %h",
                 $sampled(exe_redirect.target), $sampled(exp_exe.target));
        errors = errors + 1;
    end

    // run limit
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, tests did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    // lowest valid entry holding pc
    function automatic lookup_t model_lookup(input word_pc_t pc);
        lookup_t res;
        begin
            res = '0;
            for (int i = `PTAB_ENTRIES - 1; i >= 0; i--)
            begin
                if (m_valid[i] && m_pc[i] == pc)
                begin
                    res.hit    = 1'b1;
                    res.idx    = ptab_idx_t'(i);
                    res.target = m_target[i];
                end
            end
            return res;
        end
    endfunction

    function automatic pd_req_t pd_op(input word_pc_t pc, input logic is_branch,
                                      input logic pred_taken, input word_pc_t pred_target);
        pd_req_t req;
        begin
            req.valid       = 1'b1;
            req.pc          = pc;
            req.is_branch   = is_branch;
            req.pred_taken  = pred_taken;
            req.pred_target = pred_target;
            return req;
        end
    endfunction

    function automatic exe_req_t exe_op(input word_pc_t pc, input logic taken,
                                        input word_pc_t target);
        exe_req_t req;
        begin
            req.valid  = 1'b1;
            req.pc     = pc;
            req.taken  = taken;
            req.target = target;
            return req;
        end
    endfunction

    // drive one cycle and advance the model past the next edge
    task automatic step(input pd_req_t pd, input exe_req_t exe);
        lookup_t   pl;
        lookup_t   el;
        redirect_t pr;
        redirect_t er;
        int        free_slot;
        begin
            @(posedge clk);
            #1;
            pd_req  = pd;
            exe_req = exe;
            pl = model_lookup(pd.pc);
            el = model_lookup(exe.pc);
            pr = '0;
            er = '0;
            free_slot = -1;
            for (int i = `PTAB_ENTRIES - 1; i >= 0; i--)
            begin
                if (!m_valid[i])
                begin
                    free_slot = i;
                end
            end
            if (pd.valid)
            begin
                if (pl.hit && pd.is_branch)
                begin
                    pr.valid  = 1'b1;
                    pr.target = pl.target;
                end
                else if (pl.hit)
                begin
                    m_valid[pl.idx] = 1'b0;
                end
                else if (pd.is_branch && pd.pred_taken)
                begin
                    pr.valid  = 1'b1;
                    pr.target = pd.pred_target;
                    // full table drops the new entry
                    if (free_slot >= 0)
                    begin
                        m_valid[free_slot]  = 1'b1;
                        m_pc[free_slot]     = pd.pc;
                        m_target[free_slot] = pd.pred_target;
                    end
                end
            end
            if (exe.valid)
            begin
                if (el.hit)
                begin
                    m_valid[el.idx] = 1'b0;
                    if (!exe.taken)
                    begin
                        er.valid  = 1'b1;
                        er.target = exe.pc + 30'd1;
                    end
                    else if (el.target != exe.target)
                    begin
                        er.valid  = 1'b1;
                        er.target = exe.target;
                    end
                end
                else if (exe.taken)
                begin
                    er.valid  = 1'b1;
                    er.target = exe.target;
                end
            end
            exp_pd_d  = pr;
            exp_exe_d = er;
        end
    endtask

    // two idle cycles so the last redirect gets checked
    task automatic end_test(input string name);
        int errs;
        begin
            step('0, '0);
            step('0, '0);
            errs = errors - test_start_errors;
            tests = tests + 1;
            if (errs == 0)
            begin
                $display("test %-10s ok", name);
            end
            else
            begin
                failed_tests = failed_tests + 1;
                $display("test %-10s bad, %0d mismatches", name, errs);
            end
            test_start_errors = errors;
        end
    endtask

    // small pc pool overlapping the entries of the full test
    task automatic random_mix(input int n);
        int      r1;
        int      r2;
        pd_req_t  pd;
        exe_req_t exe;
        begin
            for (int k = 0; k < n; k++)
            begin
                r1 = $random(seed);
                r2 = $random(seed);
                pd.valid       = r1[0] | r1[1];
                pd.pc          = 30'h200 + word_pc_t'(r1[6:2]);
                pd.is_branch   = r1[7] | r1[8];
                pd.pred_taken  = r1[9];
                pd.pred_target = 30'ha00 + word_pc_t'(r1[13:10]);
                exe.valid      = r2[0];
                exe.pc         = 30'h200 + word_pc_t'(r2[5:1]);
                exe.taken      = r2[6];
                exe.target     = 30'ha00 + word_pc_t'(r2[9:7]);
                step(pd, exe);
            end
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    initial
    begin
        clk       = 1'b0;
        rstn      = 1'b0;
        pd_req    = '0;
        exe_req   = '0;
        exp_pd_d  = '0;
        exp_exe_d = '0;
        m_valid   = '0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;

        step(pd_op(30'h040, 1'b1, 1'b0, 30'h0), '0);
        end_test("reset");

        step(pd_op(30'h050, 1'b1, 1'b1, 30'h900), '0);
        step(pd_op(30'h050, 1'b1, 1'b0, 30'h0), '0);
        end_test("alloc");

        step(pd_op(30'h050, 1'b0, 1'b0, 30'h0), '0);
        step(pd_op(30'h050, 1'b1, 1'b0, 30'h0), '0);
        end_test("stale");

        // not taken, wrong target, right target, then two misses
        step(pd_op(30'h060, 1'b1, 1'b1, 30'h910), '0);
        step(pd_op(30'h070, 1'b1, 1'b1, 30'h920), exe_op(30'h060, 1'b0, 30'h0));
        step(pd_op(30'h080, 1'b1, 1'b1, 30'h930), exe_op(30'h070, 1'b1, 30'h921));
        step('0, exe_op(30'h080, 1'b1, 30'h930));
        step('0, exe_op(30'h090, 1'b1, 30'h940));
        step('0, exe_op(30'h0a0, 1'b0, 30'h950));
        step(pd_op(30'h060, 1'b1, 1'b0, 30'h0), '0);
        step(pd_op(30'h070, 1'b1, 1'b0, 30'h0), '0);
        step(pd_op(30'h080, 1'b1, 1'b0, 30'h0), '0);
        end_test("execute");

        for (int i = 0; i <= `PTAB_ENTRIES; i++)
        begin
            step(pd_op(30'h200 + word_pc_t'(i), 1'b1, 1'b1, 30'ha00 + word_pc_t'(i)), '0);
        end
        for (int i = 0; i <= `PTAB_ENTRIES; i++)
        begin
            step(pd_op(30'h200 + word_pc_t'(i), 1'b1, 1'b0, 30'h0), '0);
        end
        end_test("full");

        random_mix(200);
        end_test("random");

        $display("tests %0d, failed %0d, mismatches %0d", tests, failed_tests, errors);
        if (errors == 0 && failed_tests == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog/exe_check.sv
module exe_check (
    input  logic                 clk,
    input  logic                 rstn,
    input  ptab_pkg::exe_req_t   req,
    input  ptab_pkg::lookup_t    lookup,
    output ptab_pkg::redirect_t  redirect
);

    import ptab_pkg::*;

    redirect_t redirect_d;
    logic      redirect_valid_q;
    word_pc_t  redirect_target_q;

    //////////////////////////////
    // outcome vs prediction
    //////////////////////////////

    always_comb
    begin
        redirect_d = '0;
        if (req.valid)
        begin
            if (lookup.hit)
            begin
                // predicted taken but fell through
                if (!req.taken)
                begin
                    redirect_d.valid  = 1'b1;
                    redirect_d.target = req.pc + word_pc_t'(1);
                end
                // taken, wrong target in the buffer
                else if (lookup.target != req.target)
                begin
                    redirect_d.valid  = 1'b1;
                    redirect_d.target = req.target;
                end
            end
            // not predicted, but taken
            else if (req.taken)
            begin
                redirect_d.valid  = 1'b1;
                redirect_d.target = req.target;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            redirect_valid_q <= 1'b0;
        end
        else
        begin
            redirect_valid_q <= redirect_d.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        redirect_target_q <= redirect_d.target;
    end

    assign redirect = '{valid: redirect_valid_q, target: redirect_target_q};

    // redirect only ever answers a request one cycle back
    a_redirect_follows_req: assert property (@(posedge clk) disable iff (!rstn)
        redirect.valid |-> $past(req.valid));

endmodule

// File: verilog/predecode_check.sv
module predecode_check (
    input  logic                 clk,
    input  logic                 rstn,
    input  ptab_pkg::pd_req_t    req,
    input  ptab_pkg::lookup_t    lookup,
    output ptab_pkg::ptab_wr_t   wr,
    output logic                 clear,
    output ptab_pkg::redirect_t  redirect
);

    import ptab_pkg::*;

    redirect_t redirect_d;
    logic      redirect_valid_q;
    word_pc_t  redirect_target_q;

    //////////////////////////////
    // decisions
    //////////////////////////////

    always_comb
    begin
        wr         = '0;
        clear      = 1'b0;
        redirect_d = '0;
        if (req.valid)
        begin
            if (lookup.hit)
            begin
                // buffered prediction is used for a real branch
                if (req.is_branch)
                begin
                    redirect_d.valid  = 1'b1;
                    redirect_d.target = lookup.target;
                end
                // stale entry, not a branch after all
                else
                begin
                    clear = 1'b1;
                end
            end
            else if (req.is_branch && req.pred_taken)
            begin
                wr.valid          = 1'b1;
                wr.pc             = req.pc;
                wr.target         = req.pred_target;
                redirect_d.valid  = 1'b1;
                redirect_d.target = req.pred_target;
            end
        end
    end

    //////////////////////////////
    // redirect register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            redirect_valid_q <= 1'b0;
        end
        else
        begin
            redirect_valid_q <= redirect_d.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        redirect_target_q <= redirect_d.target;
    end

    assign redirect = '{valid: redirect_valid_q, target: redirect_target_q};

endmodule

// File: verilog/ptab.sv
`include "ptab_consts.svh"

module ptab (
    input  logic                 clk,
    input  logic                 rstn,
    input  ptab_pkg::word_pc_t   pd_pc,
    input  ptab_pkg::word_pc_t   exe_pc,
    input  logic                 exe_valid,
    input  logic                 pd_clear,
    input  ptab_pkg::ptab_wr_t   wr,
    output ptab_pkg::lookup_t    pd_lookup,
    output ptab_pkg::lookup_t    exe_lookup
);

    import ptab_pkg::*;

    logic [`PTAB_ENTRIES-1:0] valid_q;
    logic [`PTAB_ENTRIES-1:0] valid_d;
    ptab_idx_t                free_idx;
    logic                     full;
    ptab_wr_t                 table_wr;
    word_pc_t [`PTAB_ENTRIES-1:0] entry_pc;
    word_pc_t [`PTAB_ENTRIES-1:0] entry_target;

    //////////////////////////////
    // free slot search
    //////////////////////////////

    // lowest clear bit of the valid vector
    always_comb
    begin
        free_idx = '0;
        for (int i = `PTAB_ENTRIES - 1; i >= 0; i--)
        begin
            if (!valid_q[i])
            begin
                free_idx = ptab_idx_t'(i);
            end
        end
    end

    assign full = &valid_q;

    // allocation is dropped when nothing is free
    always_comb
    begin
        table_wr       = wr;
        table_wr.valid = wr.valid && !full;
    end

    //////////////////////////////
    // storage and lookups
    //////////////////////////////

    ptab_table u_table (
        .clk          (clk),
        .wr           (table_wr),
        .wr_idx       (free_idx),
        .entry_pc     (entry_pc),
        .entry_target (entry_target)
    );

    ptab_match u_pd_match (
        .pc           (pd_pc),
        .valid        (valid_q),
        .entry_pc     (entry_pc),
        .entry_target (entry_target),
        .result       (pd_lookup)
    );

    ptab_match u_exe_match (
        .pc           (exe_pc),
        .valid        (valid_q),
        .entry_pc     (entry_pc),
        .entry_target (entry_target),
        .result       (exe_lookup)
    );

    //////////////////////////////
    // valid vector
    //////////////////////////////

    // set goes to a free slot and clears hit live ones,
    // so the order below never matters
    always_comb
    begin
        valid_d = valid_q;
        if (table_wr.valid)
        begin
            valid_d[free_idx] = 1'b1;
        end
        if (pd_clear)
        begin
            valid_d[pd_lookup.idx] = 1'b0;
        end
        // execute always retires its entry
        if (exe_valid && exe_lookup.hit)
        begin
            valid_d[exe_lookup.idx] = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q <= valid_d;
        end
    end

    // new entry must land in an empty slot
    a_alloc_free: assert property (@(posedge clk) disable iff (!rstn)
        table_wr.valid |-> !valid_q[free_idx]);

    // pre-decode clear only for a live hit
    a_clear_valid: assert property (@(posedge clk) disable iff (!rstn)
        pd_clear |-> pd_lookup.hit && valid_q[pd_lookup.idx]);

endmodule

// File: verilog/ptab_frontend.sv
module ptab_frontend (
    input  logic                 clk,
    input  logic                 rstn,
    input  ptab_pkg::pd_req_t    pd_req,
    input  ptab_pkg::exe_req_t   exe_req,
    output ptab_pkg::redirect_t  pd_redirect,
    output ptab_pkg::redirect_t  exe_redirect
);

    import ptab_pkg::*;

    lookup_t  pd_lookup;
    lookup_t  exe_lookup;
    ptab_wr_t ptab_wr;
    logic     pd_clear;

    //////////////////////////////
    // target buffer
    //////////////////////////////

    // both stages look up with the raw request pc
    ptab u_ptab (
        .clk        (clk),
        .rstn       (rstn),
        .pd_pc      (pd_req.pc),
        .exe_pc     (exe_req.pc),
        .exe_valid  (exe_req.valid),
        .pd_clear   (pd_clear),
        .wr         (ptab_wr),
        .pd_lookup  (pd_lookup),
        .exe_lookup (exe_lookup)
    );

    //////////////////////////////
    // stage checkers
    //////////////////////////////

    predecode_check u_predecode_check (
        .clk      (clk),
        .rstn     (rstn),
        .req      (pd_req),
        .lookup   (pd_lookup),
        .wr       (ptab_wr),
        .clear    (pd_clear),
        .redirect (pd_redirect)
    );

    // execute retires the entry inside ptab, only the redirect comes from here
    exe_check u_exe_check (
        .clk      (clk),
        .rstn     (rstn),
        .req      (exe_req),
        .lookup   (exe_lookup),
        .redirect (exe_redirect)
    );

endmodule

// File: verilog/ptab_match.sv
`include "ptab_consts.svh"

module ptab_match (
    input  ptab_pkg::word_pc_t                      pc,
    input  logic [`PTAB_ENTRIES-1:0]                valid,
    input  ptab_pkg::word_pc_t [`PTAB_ENTRIES-1:0]  entry_pc,
    input  ptab_pkg::word_pc_t [`PTAB_ENTRIES-1:0]  entry_target,
    output ptab_pkg::lookup_t                       result
);

    import ptab_pkg::*;

    //////////////////////////////
    // priority compare
    //////////////////////////////

    // scan from the top so the lowest matching entry wins
    // miss leaves index and target at zero
    always_comb
    begin
        result = '0;
        for (int i = `PTAB_ENTRIES - 1; i >= 0; i--)
        begin
            if (valid[i] && (entry_pc[i] == pc))
            begin
                result.hit    = 1'b1;
                result.idx    = ptab_idx_t'(i);
                result.target = entry_target[i];
            end
        end

        // a reported hit must name a live entry, otherwise the
        // clear logic in ptab would retire the wrong slot
        if (result.hit)
        begin
            assert (valid[result.idx])
            else $error("ptab_match: hit on invalid entry %0d", result.idx);
        end
    end

endmodule

// File: verilog/ptab_pkg.sv
`include "ptab_consts.svh"

package ptab_pkg;

    //////////////////////////////
    // scalar types
    //////////////////////////////

    typedef logic [`PC_W-1:0]       word_pc_t;
    typedef logic [`PTAB_IDX_W-1:0] ptab_idx_t;

    //////////////////////////////
    // bundles
    //////////////////////////////

    // result of one table lookup
    typedef struct packed {
        logic      hit;
        ptab_idx_t idx;
        word_pc_t  target;
    } lookup_t;

    // pre-decode request, one-cycle strobe on valid
    typedef struct packed {
        logic     valid;
        word_pc_t pc;
        logic     is_branch;
        logic     pred_taken;
        word_pc_t pred_target;
    } pd_req_t;

    // resolved branch from execute, target is the actual one
    typedef struct packed {
        logic     valid;
        word_pc_t pc;
        logic     taken;
        word_pc_t target;
    } exe_req_t;

    typedef struct packed {
        logic     valid;
        word_pc_t target;
    } redirect_t;

    // allocation of a new entry
    typedef struct packed {
        logic     valid;
        word_pc_t pc;
        word_pc_t target;
    } ptab_wr_t;

endpackage

// File: verilog/ptab_table.sv
`include "ptab_consts.svh"

module ptab_table (
    input  logic                                        clk,
    input  ptab_pkg::ptab_wr_t                          wr,
    input  ptab_pkg::ptab_idx_t                         wr_idx,
    output ptab_pkg::word_pc_t [`PTAB_ENTRIES-1:0]      entry_pc,
    output ptab_pkg::word_pc_t [`PTAB_ENTRIES-1:0]      entry_target
);

    //////////////////////////////
    // storage
    //////////////////////////////

    // pair at wr_idx written on a valid allocation
    always_ff @(posedge clk)
    begin
        if (wr.valid)
        begin
            entry_pc[wr_idx]     <= wr.pc;
            entry_target[wr_idx] <= wr.target;
        end
    end

endmodule
